//--- Makefile
# Verilator build and run of the AXI4-Lite to APB bridge testbench
# The run passes only if the simulation output holds the pass line

TOOL       := verilator
TOP        := tb_axil_apb_bridge
FLIST      := axil_apb_bridge.f
OBJDIR     := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
PASS       := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS)'

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

//--- axil_apb_bridge.f
source/amba_pkg.sv
source/bridge_pkg.sv
source/apb_req_if.sv
source/axil_req_capture.sv
source/apb_fsm.sv
source/apb_wait_timer.sv
source/axil_resp.sv
source/axil_apb_bridge.sv
bench/tb_clk_gen.sv
bench/apb_slave_model.sv
bench/tb_axil_apb_bridge.sv

//--- bench/apb_slave_model.sv
// APB completer model for the bridge testbench
// 64-word memory with a settable number of wait states, one address that
// answers with PSLVERR and one that never raises PREADY
`timescale 1ns/100ps

module apb_slave_model #(
  parameter int          depth     = 64,
  parameter logic [31:0] err_addr  = 32'h0000_0FFC,
  parameter logic [31:0] hang_addr = 32'h0000_0FF8
) (
  input  logic        clk,
  input  logic        rst,
  input  int          wait_states,
  input  logic [31:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  pstrb,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int idx_width = $clog2(depth);

  logic [31:0]          mem [depth];
  logic [idx_width-1:0] idx;
  int                   wait_cnt;

  // Word index, byte offset dropped
  assign idx = paddr[idx_width+1:2];

  // Every word differs, so a wrong index shows up in the data
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = {8'hA5, 8'(i), 8'(~i), 8'(i * 7)};
    end
  end

  // ACCESS cycles seen so far for the current transfer
  always @(posedge clk) begin
    if (rst || !(psel && penable) || pready) begin
      wait_cnt <= 0;
    end else begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  assign pready  = psel && penable && (paddr != hang_addr) && (wait_cnt >= wait_states);
  assign pslverr = pready && (paddr == err_addr);
  assign prdata  = mem[idx];

  // Byte-lane write, skipped on an error response
  always @(posedge clk) begin
    if (psel && penable && pready && pwrite && !pslverr) begin
      if (pstrb[0]) mem[idx][7:0]   <= pwdata[7:0];
      if (pstrb[1]) mem[idx][15:8]  <= pwdata[15:8];
      if (pstrb[2]) mem[idx][23:16] <= pwdata[23:16];
      if (pstrb[3]) mem[idx][31:24] <= pwdata[31:24];
    end
  end

endmodule

//--- bench/tb_axil_apb_bridge.sv
// Directed testbench for the AXI4-Lite to APB bridge
// Drives the AXI side 1 ns after each rising edge, samples on the falling
// edge, and uses an APB memory model as the completer
`timescale 1ns/100ps

module tb_axil_apb_bridge;

  localparam int          timeout_cycles = 16;
  // About 20 transactions of under 40 cycles each plus a wide margin
  localparam int          max_cycles     = 4000;
  localparam logic [31:0] addr_a         = 32'h0000_0010;
  localparam logic [31:0] addr_b         = 32'h0000_0024;
  localparam logic [31:0] addr_c         = 32'h0000_0038;
  localparam logic [31:0] err_addr       = 32'h0000_0FFC;
  localparam logic [31:0] hang_addr      = 32'h0000_0FF8;
  // AXI response encodings
  localparam logic [1:0]  axi_okay       = 2'b00;
  localparam logic [1:0]  axi_slverr     = 2'b10;

  logic        clk;
  logic        rst;
  logic [31:0] awaddr;
  logic [2:0]  awprot;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic [2:0]  arprot;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic [2:0]  pprot;
  logic [3:0]  pstrb;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          wait_states;
  int          errors;
  int          checks;
  int          tests;
  int          cycles;
  int          psel_run;
  int          last_psel_run;
  logic [2:0]  last_pprot;
  logic [31:0] lfsr;
  logic [31:0] shadow_a;
  // pwrite of each completed APB transfer, in order
  logic        apb_order[$];

  tb_clk_gen #(.period(10), .reset_cycles(4)) u_clk (.clk(clk), .rst(rst));

  axil_apb_bridge #(
    .addr_width     (32),
    .data_width     (32),
    .timeout_cycles (timeout_cycles)
  ) u_dut (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .paddr(paddr), .psel(psel), .penable(penable), .pprot(pprot),
    .pstrb(pstrb), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr)
  );

  apb_slave_model #(.depth(64), .err_addr(err_addr), .hang_addr(hang_addr)) u_apb (
    .clk(clk), .rst(rst), .wait_states(wait_states),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pstrb(pstrb), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr)
  );

  // --------------------------------------------------------------------------
  // Monitors and watchdog
  // --------------------------------------------------------------------------

  // Length of the last psel pulse and APB completion order
  always @(negedge clk) begin
    if (psel) begin
      psel_run = psel_run + 1;
    end else if (psel_run != 0) begin
      last_psel_run = psel_run;
      psel_run = 0;
    end
    if (psel && penable && pready) begin
      apb_order.push_back(pwrite);
      last_pprot = pprot;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // APB byte-lane write rule
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] m;
    m = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m[8*b +: 8] = new_word[8*b +: 8];
    end
    return m;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      $display("[FAIL] %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("[done] %s: %0d errors", name, errors - errs_before);
  endtask

  // AXI write where hold is the number of cycles bvalid waits on bready
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold,
                           output logic [1:0] resp, output int lat);
    int held;
    @(posedge clk);
    #1;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    bready  = 1'b0;
    @(negedge clk);
    while (!awready) begin
      @(posedge clk);
      #1;
      @(negedge clk);
    end
    expect_true("wready with awready", wready);
    // Grant cycle is lat 0
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      lat++;
      @(negedge clk);
    end while (!bvalid);
    held = 1;
    expect_true("APB and AXI readies quiet in B hold",
                !psel && !penable && !awready && !wready && !arready);
    // Pending requests must not be granted during the hold
    while (held < hold) begin
      @(posedge clk);
      #1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      araddr  = addr;
      arvalid = 1'b1;
      held++;
      @(negedge clk);
      expect_true("bvalid held", bvalid);
      expect_true("APB and AXI readies quiet in B hold",
                  !psel && !penable && !awready && !wready && !arready);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b1;
    @(negedge clk);
    expect_true("bvalid at handshake", bvalid);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output int lat);
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    while (!arready) begin
      @(posedge clk);
      #1;
      @(negedge clk);
    end
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      lat++;
      @(negedge clk);
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_write_read();
    logic [1:0]  resp;
    logic [31:0] rd;
    int          lat;
    int          errs0;
    errs0       = errors;
    wait_states = 0;
    shadow_a    = rand_bits(32);
    awprot      = 3'b101;
    axi_write(addr_a, shadow_a, 4'hF, 1, resp, lat);
    expect_eq("write bresp", 32'(resp), 32'(axi_okay));
    // SETUP, one ACCESS, then B
    expect_eq("bvalid cycles after grant", 32'(lat), 32'd3);
    expect_eq("write pprot", 32'(last_pprot), 32'(3'b101));
    arprot      = 3'b010;
    axi_read(addr_a, rd, resp, lat);
    expect_eq("read back data", rd, shadow_a);
    expect_eq("read rresp", 32'(resp), 32'(axi_okay));
    expect_eq("read pprot", 32'(last_pprot), 32'(3'b010));
    report_test("write then read back", errs0);
  endtask

  task automatic test_partial_strobe();
    logic [1:0]  resp;
    logic [31:0] rd;
    logic [31:0] data;
    logic [3:0]  strb;
    int          lat;
    int          errs0;
    errs0 = errors;
    data  = rand_bits(32);
    strb  = 4'(rand_bits(4));
    // Keep it a real partial write
    if (strb == 4'h0 || strb == 4'hF) strb = 4'b0110;
    axi_write(addr_a, data, strb, 1, resp, lat);
    expect_eq("strobed write bresp", 32'(resp), 32'(axi_okay));
    shadow_a = merge_bytes(shadow_a, data, strb);
    axi_read(addr_a, rd, resp, lat);
    expect_eq("merged word", rd, shadow_a);
    report_test("partial strobes", errs0);
  endtask

  task automatic test_wait_backpressure();
    logic [1:0]  resp;
    logic [31:0] rd;
    logic [31:0] data;
    int          lat;
    int          errs0;
    errs0       = errors;
    wait_states = 5;
    data        = rand_bits(32);
    axi_write(addr_b, data, 4'hF, 3, resp, lat);
    expect_eq("waited write bresp", 32'(resp), 32'(axi_okay));
    expect_eq("waited write latency", 32'(lat), 32'(3 + 5));
    axi_read(addr_b, rd, resp, lat);
    expect_eq("waited read data", rd, data);
    expect_eq("waited read latency", 32'(lat), 32'(3 + 5));
    wait_states = 0;
    report_test("wait states and back-pressure", errs0);
  endtask

  task automatic test_slave_error();
    logic [1:0]  resp;
    logic [31:0] rd;
    int          lat;
    int          errs0;
    errs0 = errors;
    axi_write(err_addr, rand_bits(32), 4'hF, 1, resp, lat);
    expect_eq("error write bresp", 32'(resp), 32'(axi_slverr));
    axi_read(err_addr, rd, resp, lat);
    expect_eq("error read rresp", 32'(resp), 32'(axi_slverr));
    report_test("slave error", errs0);
  endtask

  task automatic test_timeout();
    logic [1:0]  resp;
    logic [31:0] rd;
    int          lat;
    int          errs0;
    errs0 = errors;
    axi_read(hang_addr, rd, resp, lat);
    expect_eq("timeout rresp", 32'(resp), 32'(axi_slverr));
    // One SETUP plus the full ACCESS allowance
    expect_eq("psel high cycles", 32'(last_psel_run), 32'(1 + timeout_cycles));
    expect_eq("timeout latency", 32'(lat), 32'(2 + timeout_cycles));
    expect_true("psel low after timeout", !psel);
    axi_read(addr_a, rd, resp, lat);
    expect_eq("read after timeout", rd, shadow_a);
    expect_eq("rresp after timeout", 32'(resp), 32'(axi_okay));
    report_test("access timeout", errs0);
  endtask

  task automatic test_arbitration();
    logic [1:0]  resp;
    logic [31:0] rd;
    logic        grants[$];
    int          lat;
    int          nw;
    int          nr;
    int          errs0;
    errs0 = errors;
    // A read last leaves write as the favored side
    axi_read(addr_a, rd, resp, lat);
    apb_order.delete();
    nw = 0;
    nr = 0;
    @(posedge clk);
    #1;
    awaddr  = addr_c;
    wdata   = rand_bits(32);
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    araddr  = addr_a;
    arvalid = 1'b1;
    bready  = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    // Both sides stay requesting, so every grant is a tie
    while (nw < 2 || nr < 2) begin
      if (awready) begin
        expect_true("wready with awready", wready);
        grants.push_back(1'b1);
        nw++;
      end
      if (arready) begin
        grants.push_back(1'b0);
        nr++;
      end
      @(posedge clk);
      #1;
      if (nw == 2) begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
      end
      if (nr == 2) arvalid = 1'b0;
      @(negedge clk);
    end
    while (!rvalid) begin
      @(posedge clk);
      #1;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    bready = 1'b0;
    rready = 1'b0;
    expect_eq("grant count", 32'(grants.size()), 32'd4);
    expect_eq("APB transfer count", 32'(apb_order.size()), 32'd4);
    for (int i = 0; i < 4; i++) begin
      expect_eq("grant order", 32'(grants[i]), 32'(i % 2 == 0));
      expect_eq("APB pwrite order", 32'(apb_order[i]), 32'(i % 2 == 0));
    end
    report_test("round-robin arbitration", errs0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    awaddr        = '0;
    awprot        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arprot        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    wait_states   = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    cycles        = 0;
    psel_run      = 0;
    last_psel_run = 0;
    last_pprot    = '0;
    lfsr          = 32'h6762_9a93;
    @(negedge rst);
    test_write_read();
    test_partial_strobe();
    test_wait_backpressure();
    test_slave_error();
    test_timeout();
    test_arbitration();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- bench/tb_clk_gen.sv
// Clock and reset source for the bridge testbench
// Free-running clock; rst high for reset_cycles edges, released 1 ns after
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int period       = 10,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Released off the edge like the other stimulus
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- source/amba_pkg.sv
// AMBA protocol definitions shared by the AXI4-Lite and APB sides
// Covers only the field widths and response codes the bridge uses
// Refer to items by scoped name, e.g. amba_pkg::resp_t

package amba_pkg;

  // ------------------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------------------

  // AxPROT and PPROT carry the same three bits
  // Privileged, non-secure, instruction
  parameter int prot_width = 3;

  // BRESP and RRESP
  parameter int resp_width = 2;

  // ------------------------------------------------------------------------
  // Response codes
  // ------------------------------------------------------------------------

  // EXOKAY and DECERR never produced here
  // APB PSLVERR and the access timeout both map to SLVERR
  typedef enum logic [resp_width-1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

endpackage

//--- source/apb_fsm.sv
// APB master phase sequencing
// IDLE -> SETUP -> ACCESS, waits for pready or the timer, then holds
// in RESP until the AXI response is taken
`timescale 1ns/100ps

module apb_fsm #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  apb_req_if.fsm                          req,
  output logic                            idle,
  output logic                            in_access,
  input  logic                            expired,
  output logic                            done,
  output logic                            done_write,
  output logic                            done_err,
  input  logic                            resp_taken,
  // APB master
  output logic [addr_width-1:0]           paddr,
  output logic                            psel,
  output logic                            penable,
  output logic [amba_pkg::prot_width-1:0] pprot,
  output logic [data_width/8-1:0]         pstrb,
  output logic                            pwrite,
  output logic [data_width-1:0]           pwdata,
  input  logic                            pready,
  input  logic                            pslverr
);

  bridge_pkg::apb_state_t state;
  bridge_pkg::apb_state_t state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= bridge_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      bridge_pkg::st_idle:   if (req.start) state_next = bridge_pkg::st_setup;
      bridge_pkg::st_setup:  state_next = bridge_pkg::st_access;
      // Timer expiry ends the transfer as if pready had come
      bridge_pkg::st_access: if (pready || expired) state_next = bridge_pkg::st_resp;
      bridge_pkg::st_resp:   if (resp_taken) state_next = bridge_pkg::st_idle;
      default:               state_next = bridge_pkg::st_idle;
    endcase
  end

  assign idle      = (state == bridge_pkg::st_idle);
  assign in_access = (state == bridge_pkg::st_access);

  // One-cycle completion strobe at the end of ACCESS
  assign done       = in_access && (pready || expired);
  assign done_write = req.write;
  // Real pready wins over a same-cycle expiry
  assign done_err   = pready ? pslverr : 1'b1;

  // ------------------------------------------------------------------------
  // APB outputs
  // ------------------------------------------------------------------------

  assign psel    = (state == bridge_pkg::st_setup) || in_access;
  assign penable = in_access;
  assign paddr   = req.addr;
  assign pprot   = req.prot;
  assign pstrb   = req.strb;
  assign pwrite  = req.write;
  assign pwdata  = req.wdata;

  state_known_a : assert property (@(posedge clk) disable iff (rst)
    !$isunknown(state));

  // Address and control hold still from SETUP to the end of the transfer
  apb_stable_a : assert property (@(posedge clk) disable iff (rst)
    psel && !done |=> $stable(paddr) && $stable(pwrite) && $stable(pprot)
      && $stable(pstrb) && $stable(pwdata));

endmodule

//--- source/apb_req_if.sv
// Captured AXI request handed from the capture stage to the APB FSM
// start pulses in the grant cycle; fields are valid from the next cycle
`timescale 1ns/100ps

interface apb_req_if #(
  parameter int addr_width = 32,
  parameter int data_width = 32
);

  logic                             start;
  logic                             write;
  logic [addr_width-1:0]            addr;
  logic [amba_pkg::prot_width-1:0]  prot;
  logic [data_width/8-1:0]          strb;
  logic [data_width-1:0]            wdata;

  // Capture side drives everything
  modport capture (output start, write, addr, prot, strb, wdata);

  // FSM only consumes
  modport fsm (input start, write, addr, prot, strb, wdata);

endinterface

//--- source/apb_wait_timer.sv
// Counts ACCESS cycles spent waiting on pready
// expired is high in the last allowed ACCESS cycle so the FSM leaves
// on that edge
`timescale 1ns/100ps

module apb_wait_timer #(
  parameter int timeout_cycles = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic in_access,
  input  logic pready,
  output logic expired
);

  // Holds 0 .. timeout_cycles-1
  localparam int cnt_width = (timeout_cycles > 1) ? $clog2(timeout_cycles) : 1;
  localparam logic [cnt_width-1:0] limit = cnt_width'(timeout_cycles - 1);

  logic [cnt_width-1:0] cnt;
  logic                 at_limit;

  assign at_limit = (cnt == limit);

  always_ff @(posedge clk) begin
    if (rst || !in_access) begin
      cnt <= '0;
    end else if (!pready && !at_limit) begin
      // Saturate at the limit
      cnt <= cnt + cnt_width'(1);
    end
  end

  assign expired = in_access && at_limit;

  // Expiry ends ACCESS on the same edge
  expired_ends_access_a : assert property (@(posedge clk) disable iff (rst)
    expired |=> !in_access);

  // No APB access outlives the timeout
  access_bounded_a : assert property (@(posedge clk) disable iff (rst)
    $rose(in_access) |-> ##[1:timeout_cycles] !in_access);

endmodule

//--- source/axil_apb_bridge.sv
// AXI4-Lite slave to APB master bridge, one transaction at a time
// Top level with plain AXI and APB ports; timeout_cycles bounds the
// wait for pready before SLVERR is returned
`timescale 1ns/100ps

module axil_apb_bridge #(
  parameter int addr_width     = bridge_pkg::default_addr_width,
  parameter int data_width     = bridge_pkg::default_data_width,
  parameter int timeout_cycles = bridge_pkg::default_timeout_cycles
) (
  input  logic                            clk,
  input  logic                            rst,
  // AXI4-Lite slave
  input  logic [addr_width-1:0]           awaddr,
  input  logic [amba_pkg::prot_width-1:0] awprot,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [data_width-1:0]           wdata,
  input  logic [data_width/8-1:0]         wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [amba_pkg::resp_width-1:0] bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [addr_width-1:0]           araddr,
  input  logic [amba_pkg::prot_width-1:0] arprot,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [data_width-1:0]           rdata,
  output logic [amba_pkg::resp_width-1:0] rresp,
  output logic                            rvalid,
  input  logic                            rready,
  // APB master
  output logic [addr_width-1:0]           paddr,
  output logic                            psel,
  output logic                            penable,
  output logic [amba_pkg::prot_width-1:0] pprot,
  output logic [data_width/8-1:0]         pstrb,
  output logic                            pwrite,
  output logic [data_width-1:0]           pwdata,
  input  logic [data_width-1:0]           prdata,
  input  logic                            pready,
  input  logic                            pslverr
);

  logic idle;
  logic in_access;
  logic expired;
  logic done;
  logic done_write;
  logic done_err;
  logic resp_taken;

  apb_req_if #(.addr_width(addr_width), .data_width(data_width)) req ();

  // ------------------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------------------

  axil_req_capture #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) u_capture (
    .clk     (clk),
    .rst     (rst),
    .idle    (idle),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .req     (req.capture)
  );

  // ------------------------------------------------------------------------
  // APB sequencing and timeout
  // ------------------------------------------------------------------------

  apb_fsm #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) u_fsm (
    .clk        (clk),
    .rst        (rst),
    .req        (req.fsm),
    .idle       (idle),
    .in_access  (in_access),
    .expired    (expired),
    .done       (done),
    .done_write (done_write),
    .done_err   (done_err),
    .resp_taken (resp_taken),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pprot      (pprot),
    .pstrb      (pstrb),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  apb_wait_timer #(
    .timeout_cycles(timeout_cycles)
  ) u_timer (
    .clk       (clk),
    .rst       (rst),
    .in_access (in_access),
    .pready    (pready),
    .expired   (expired)
  );

  // ------------------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------------------

  // Read data comes straight off prdata
  axil_resp #(
    .data_width(data_width)
  ) u_resp (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .done_write (done_write),
    .done_err   (done_err),
    .prdata     (prdata),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .resp_taken (resp_taken)
  );

endmodule

//--- source/axil_req_capture.sv
// AXI4-Lite request side of the bridge
// Arbitrates read against write, returns the AXI readies and registers
// the granted request for the APB FSM
`timescale 1ns/100ps

module axil_req_capture #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            idle,
  // AW channel
  input  logic [addr_width-1:0]           awaddr,
  input  logic [amba_pkg::prot_width-1:0] awprot,
  input  logic                            awvalid,
  output logic                            awready,
  // W channel
  input  logic [data_width-1:0]           wdata,
  input  logic [data_width/8-1:0]         wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  // AR channel
  input  logic [addr_width-1:0]           araddr,
  input  logic [amba_pkg::prot_width-1:0] arprot,
  input  logic                            arvalid,
  output logic                            arready,
  apb_req_if.capture                      req
);

  logic write_req;
  logic read_req;
  logic write_grant;
  logic read_grant;
  // Set when the last grant went to a write
  logic last_write;

  // ------------------------------------------------------------------------
  // Round-robin arbiter
  // ------------------------------------------------------------------------

  // Write needs AW and W together, no split channels
  assign write_req = idle && awvalid && wvalid;
  assign read_req  = idle && arvalid;

  // Alone wins outright; on a tie the side not served last goes
  assign write_grant = write_req && (!read_req || !last_write);
  assign read_grant  = read_req && (!write_req || last_write);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Read counts as last so write goes first out of reset
      last_write <= 1'b0;
    end else if (write_grant || read_grant) begin
      last_write <= write_grant;
    end
  end

  // Ready in the same cycle as the grant
  assign awready = write_grant;
  assign wready  = write_grant;
  assign arready = read_grant;

  // ------------------------------------------------------------------------
  // Request registers
  // ------------------------------------------------------------------------

  assign req.start = write_grant || read_grant;

  always_ff @(posedge clk) begin
    if (write_grant || read_grant) begin
      req.write <= write_grant;
      req.addr  <= write_grant ? awaddr : araddr;
      req.prot  <= write_grant ? awprot : arprot;
      req.wdata <= wdata;
      // APB wants PSTRB low on reads
      req.strb  <= write_grant ? wstrb : '0;
    end
  end

  // Each grant must take the bridge out of idle on the next cycle
  grant_only_when_idle_a : assert property (@(posedge clk) disable iff (rst)
    (awready || arready) |-> idle ##1 !idle);

endmodule

//--- source/axil_resp.sv
// AXI4-Lite B and R response channels
// Latches the APB result on done and holds valid until the handshake
`timescale 1ns/100ps

module axil_resp #(
  parameter int data_width = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            done,
  input  logic                            done_write,
  input  logic                            done_err,
  input  logic [data_width-1:0]           prdata,
  output logic [amba_pkg::resp_width-1:0] bresp,
  output logic                            bvalid,
  input  logic                            bready,
  output logic [amba_pkg::resp_width-1:0] rresp,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [data_width-1:0]           rdata,
  output logic                            resp_taken
);

  amba_pkg::resp_t resp_q;

  // Valid flags
  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else if (done) begin
      bvalid <= done_write;
      rvalid <= !done_write;
    end else if (resp_taken) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
  end

  // Payload shared by B and R
  always_ff @(posedge clk) begin
    if (done) begin
      resp_q <= done_err ? amba_pkg::resp_slverr : amba_pkg::resp_okay;
      if (!done_write) begin
        rdata <= prdata;
      end
    end
  end

  assign bresp = resp_q;
  assign rresp = resp_q;

  // Frees the FSM from RESP
  assign resp_taken = (bvalid && bready) || (rvalid && rready);

  // A new APB result never lands on a response still waiting
  no_resp_overrun_a : assert property (@(posedge clk) disable iff (rst)
    done |-> !bvalid && !rvalid);

endmodule

//--- source/bridge_pkg.sv
// Bridge-specific definitions
// APB phase state encoding and default sizes for the top level

package bridge_pkg;

  // APB phase state, one-hot
  // RESP holds the AXI response until the B or R handshake
  typedef enum logic [3:0] {
    st_idle   = 4'b0001,
    st_setup  = 4'b0010,
    st_access = 4'b0100,
    st_resp   = 4'b1000
  } apb_state_t;

  // ------------------------------------------------------------------------
  // Default sizes
  // ------------------------------------------------------------------------

  parameter int default_addr_width = 32;
  parameter int default_data_width = 32;

  // ACCESS cycles allowed before the bridge gives up on pready
  parameter int default_timeout_cycles = 16;

endpackage
